/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_gpio \
  --Mdir obj_dir -o tb_gpio_sim || exit 1
out=$(./obj_dir/tb_gpio_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^Test completed successfully$" && echo "PASS" || { echo "FAIL"; exit 1; }

/* sources.f */
verilog/bus_pkg.sv
verilog/gpio_pkg.sv
verilog/bus_req_if.sv
verilog/req_queue.sv
verilog/gpio_in_sync.sv
verilog/gpio_ctrl.sv
verilog/gpio_top.sv
verif/gpio_sva.sv
verif/tb_gpio.sv

/* verif/gpio_sva.sv */
`timescale 1ns/1ns

module gpio_sva (
  input logic clk,
  input logic nrst,
  input logic i_valid,
  input logic i_full,
  input logic i_credit,
  input logic i_rd_req,
  input logic i_rsp_valid
);

  int err_cnt = 0;

  // host must hold a credit for every request
  a_no_push_full: assert property (@(posedge clk) disable iff (!nrst) i_valid |-> !i_full)
    else begin
      err_cnt++;
      $error("request arrived while the queue was full");
    end

  a_rsp_after_read: assert property (@(posedge clk) disable iff (!nrst)
    i_rsp_valid |-> $past(i_rd_req))
    else begin
      err_cnt++;
      $error("read response without a presented read");
    end

  a_credit_reset: assert property (@(posedge clk) !nrst |-> !i_credit)
    else begin
      err_cnt++;
      $error("credit pulse during reset");
    end

endmodule : gpio_sva

bind req_queue gpio_sva queue_sva_i (
  .clk (clk), .nrst (nrst), .i_valid (i_valid), .i_full (full),
  .i_credit (o_credit), .i_rd_req (1'b0), .i_rsp_valid (1'b0)
);

bind gpio_ctrl gpio_sva ctrl_sva_i (
  .clk (clk), .nrst (nrst), .i_valid (1'b0), .i_full (1'b0),
  .i_credit (1'b0), .i_rd_req (q.valid && !q.we), .i_rsp_valid (o_rsp_valid)
);

/* verif/tb_gpio.sv */
`timescale 1ns/1ns

module tb_gpio;
  import bus_pkg::*;
  import gpio_pkg::*;

  localparam int WIDTH = 12;
  localparam int DEPTH = 4;
  localparam logic [2:0] K_WR = 3'd0, K_RD = 3'd1, K_PIN = 3'd2;
  localparam logic [2:0] K_OUTS = 3'd3, K_RDB = 3'd4, K_DRAIN = 3'd5;

  typedef struct packed {
    logic [2:0] kind;
    bus_addr_t  addr;
    bus_strb_t  strb;
    bus_data_t  data;
    bus_data_t  exp;
  } row_t;

  logic clk, nrst, i_req_valid, i_req_we;
  bus_addr_t i_req_addr;
  bus_data_t i_req_wdata;
  bus_strb_t i_req_strb;
  logic o_credit, o_rsp_valid, o_irq;
  bus_data_t o_rsp_rdata;
  logic [WIDTH-1:0] i_gpio, o_gpio, o_gpio_dir;

  row_t rows[$];
  bus_data_t exp_q[$];
  int tag_q[$];
  int credits, cycles, cycle_limit;
  logic [31:0] seed = 32'hfb73_85ee;
  logic [WIDTH-1:0] m_dir, m_out, m_en, m_stat, m_pins;  // register model

  gpio_top #(.WIDTH (WIDTH), .DEPTH (DEPTH)) gpio_top_i (
    .clk (clk), .nrst (nrst), .i_req_valid (i_req_valid), .i_req_we (i_req_we),
    .i_req_addr (i_req_addr), .i_req_wdata (i_req_wdata), .i_req_strb (i_req_strb),
    .o_credit (o_credit), .o_rsp_valid (o_rsp_valid), .o_rsp_rdata (o_rsp_rdata),
    .i_gpio (i_gpio), .o_gpio (o_gpio), .o_gpio_dir (o_gpio_dir), .o_irq (o_irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic bus_data_t rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed;
  endfunction

  task automatic check(input bus_data_t actual, input bus_data_t expected, input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic bus_data_t model_read(input bus_addr_t addr);
    bus_data_t v;
    v = '0;
    case (addr)
      REG_DIR:      v[WIDTH-1:0] = m_dir;
      REG_IN:       v[WIDTH-1:0] = m_pins;
      REG_OUT:      v[WIDTH-1:0] = m_out;
      REG_IRQ_EN:   v[WIDTH-1:0] = m_en;
      REG_IRQ_STAT: v[WIDTH-1:0] = m_stat;
      default:      v = '0;
    endcase
    return v;
  endfunction

  task automatic add_write(input bus_addr_t addr, input bus_strb_t strb, input bus_data_t data);
    logic [WIDTH-1:0] w;
    w = data[WIDTH-1:0];
    rows.push_back(row_t'{K_WR, addr, strb, data, 32'd0});
    if (strb != '0) begin
      case (addr)
        REG_DIR:      m_dir = w;
        REG_OUT:      m_out = w;
        REG_IRQ_EN:   m_en = w;
        REG_IRQ_STAT: m_stat = m_stat & ~w;  // write one to clear
        default:      ;
      endcase
    end
  endtask

  task automatic add_read(input bus_addr_t addr, input logic burst);
    rows.push_back(row_t'{burst ? K_RDB : K_RD, addr, 4'h0, 32'd0, model_read(addr)});
  endtask

  task automatic add_pins(input logic [WIDTH-1:0] p);
    rows.push_back(row_t'{K_PIN, 4'h0, 4'h0, 32'(p), 32'd0});
    m_stat = m_stat | (p & ~m_pins & m_en);
    m_pins = p;
  endtask

  task automatic add_outs();
    rows.push_back(row_t'{K_OUTS, 4'h0, 4'h0, 32'd0, 32'({|(m_stat & m_en), m_dir, m_out})});
  endtask

  task automatic build_table();
    logic [WIDTH-1:0] p;
    logic [WIDTH-1:0] m;
    m_dir = '1;
    m_out = '0;
    m_en = '0;
    m_stat = '0;
    m_pins = '0;
    add_outs();
    add_read(REG_DIR, 1'b0);
    add_read(REG_OUT, 1'b0);
    add_read(4'd7, 1'b0);  // unmapped
    repeat (4) begin
      add_write(REG_DIR, 4'hf, rand32());
      add_write(REG_OUT, 4'hf, rand32());
      add_outs();
      add_read(REG_DIR, 1'b0);
      add_read(REG_OUT, 1'b0);
    end
    add_write(REG_DIR, 4'h0, rand32());
    add_write(REG_OUT, 4'h0, rand32());
    add_read(REG_DIR, 1'b0);
    add_outs();
    repeat (4) begin
      add_pins(WIDTH'(rand32()));
      add_read(REG_IN, 1'b0);
    end
    add_write(REG_IN, 4'hf, rand32());
    add_read(REG_IN, 1'b0);
    add_pins('0);
    m = WIDTH'(rand32());
    p = WIDTH'(rand32());
    m[0] = 1'b1;  // at least one enabled rising pin
    p[0] = 1'b1;
    add_write(REG_IRQ_EN, 4'hf, 32'(m));
    add_pins(p);
    add_read(REG_IRQ_STAT, 1'b0);
    add_outs();
    add_write(REG_IRQ_STAT, 4'hf, 32'(p & m));
    add_read(REG_IRQ_STAT, 1'b0);
    add_outs();
    for (int k = 0; k < DEPTH; k++) add_read(bus_addr_t'(k), 1'b1);
    rows.push_back(row_t'{K_DRAIN, 4'h0, 4'h0, 32'd0, 32'd0});
  endtask

  task automatic send(input logic we, input bus_addr_t addr, input bus_strb_t strb,
                      input bus_data_t data);
    while (credits <= 0) @(negedge clk);
    i_req_valid = 1'b1;
    i_req_we = we;
    i_req_addr = addr;
    i_req_strb = strb;
    i_req_wdata = data;
    @(negedge clk);
    i_req_valid = 1'b0;
  endtask

  task automatic wait_responses();
    do @(posedge clk); while (exp_q.size() != 0);
    @(negedge clk);
  endtask

  always @(posedge clk or negedge nrst) begin
    if (!nrst) credits <= DEPTH;
    else credits <= credits - int'(i_req_valid) + int'(o_credit);
  end

  always @(negedge clk) begin
    if (nrst && o_rsp_valid) begin
      if (exp_q.size() == 0) begin
        $display("read response arrived with no read outstanding at %0t", $time);
        $display("Test failed");
        $fatal(1, "unexpected response");
      end else begin
        check(o_rsp_rdata, exp_q.pop_front(), $sformatf("read of row %0d", tag_q.pop_front()));
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    row_t r;
    int sva_errors;
    nrst = 1'b0;
    i_req_valid = 1'b0;
    i_req_we = 1'b0;
    i_req_addr = '0;
    i_req_wdata = '0;
    i_req_strb = '0;
    i_gpio = '0;
    cycle_limit = 0;
    build_table();
    cycle_limit = 20 * rows.size() + 50;
    repeat (3) @(negedge clk);
    nrst = 1'b1;
    foreach (rows[i]) begin
      r = rows[i];
      case (r.kind)
        K_WR: send(1'b1, r.addr, r.strb, r.data);
        K_RD, K_RDB: begin
          exp_q.push_back(r.exp);
          tag_q.push_back(i);
          send(1'b0, r.addr, 4'h0, 32'd0);
          if (r.kind == K_RD) wait_responses();
        end
        K_PIN: begin
          i_gpio = r.data[WIDTH-1:0];
          repeat (4) @(negedge clk);
        end
        K_OUTS: begin
          repeat (2) @(negedge clk);  // write lands two edges after acceptance
          check(32'(o_gpio), 32'(r.exp[WIDTH-1:0]), $sformatf("o_gpio, row %0d", i));
          check(32'(o_gpio_dir), 32'(r.exp[2*WIDTH-1:WIDTH]), $sformatf("o_gpio_dir, row %0d", i));
          check(32'(o_irq), 32'(r.exp[2*WIDTH]), $sformatf("o_irq, row %0d", i));
        end
        default: begin
          wait_responses();
          check(32'(credits), 32'(DEPTH), "credits after back-to-back reads");
        end
      endcase
    end
    sva_errors = gpio_top_i.req_queue_i.queue_sva_i.err_cnt
               + gpio_top_i.gpio_ctrl_i.ctrl_sva_i.err_cnt;
    if (sva_errors != 0) begin
      $display("%0d assertion failures were reported", sva_errors);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule : tb_gpio

/* verilog/bus_pkg.sv */
package bus_pkg;

  // word index into sixteen register slots
  typedef logic [3:0] bus_addr_t;

  // one 32-bit data word per transfer
  typedef logic [31:0] bus_data_t;

  // byte enables for the data word
  typedef logic [3:0] bus_strb_t;

endpackage : bus_pkg

/* verilog/bus_req_if.sv */
`timescale 1ns/1ns

interface bus_req_if;
  import bus_pkg::*;

  logic      valid;
  logic      we;
  bus_addr_t addr;
  bus_data_t wdata;
  bus_strb_t strb;

  // queue side drives the head entry
  modport src (
    output valid,
    output we,
    output addr,
    output wdata,
    output strb
  );

  // controller side consumes it in the same cycle
  modport dst (
    input valid,
    input we,
    input addr,
    input wdata,
    input strb
  );

endinterface : bus_req_if

/* verilog/gpio_ctrl.sv */
`timescale 1ns/1ns

module gpio_ctrl #(
  parameter int WIDTH = 12
) (
  input  logic               clk,
  input  logic               nrst,
  bus_req_if.dst             q,
  input  logic [WIDTH-1:0]   i_level,
  input  logic [WIDTH-1:0]   i_rise,
  output logic               o_rsp_valid,
  output bus_pkg::bus_data_t o_rsp_rdata,
  output logic [WIDTH-1:0]   o_gpio,
  output logic [WIDTH-1:0]   o_gpio_dir,
  output logic               o_irq
);
  import bus_pkg::*;
  import gpio_pkg::*;

  logic [WIDTH-1:0] dir_r;
  logic [WIDTH-1:0] out_r;
  logic [WIDTH-1:0] irq_en_r;
  logic [WIDTH-1:0] irq_stat_r;
  logic [WIDTH-1:0] wval;
  logic [WIDTH-1:0] stat_clr;
  logic             wr_en;
  logic             rd_en;
  bus_data_t        rd_data;

  assign wval  = q.wdata[WIDTH-1:0];  // bits above the pin count are dropped
  assign wr_en = q.valid && q.we && (q.strb != '0);
  assign rd_en = q.valid && !q.we;

  assign stat_clr = (wr_en && (q.addr == REG_IRQ_STAT)) ? wval : '0;

  always_comb begin
    rd_data = '0;
    case (q.addr)
      REG_DIR:      rd_data[WIDTH-1:0] = dir_r;
      REG_IN:       rd_data[WIDTH-1:0] = i_level;
      REG_OUT:      rd_data[WIDTH-1:0] = out_r;
      REG_IRQ_EN:   rd_data[WIDTH-1:0] = irq_en_r;
      REG_IRQ_STAT: rd_data[WIDTH-1:0] = irq_stat_r;
      default:      ;  // unmapped index reads zero
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dir_r    <= DIR_RESET[WIDTH-1:0];
      out_r    <= '0;
      irq_en_r <= '0;
    end else if (wr_en) begin
      case (q.addr)
        REG_DIR:    dir_r    <= wval;
        REG_OUT:    out_r    <= wval;
        REG_IRQ_EN: irq_en_r <= wval;
        default:    ;  // IN and unmapped ignore writes
      endcase
    end
  end

  // new edge wins over a clear in the same cycle
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      irq_stat_r <= '0;
    end else begin
      irq_stat_r <= (irq_stat_r & ~stat_clr) | (i_rise & irq_en_r);
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_rsp_rdata <= rd_data;
    end
  end

  assign o_gpio     = out_r;
  assign o_gpio_dir = dir_r;
  assign o_irq      = |(irq_stat_r & irq_en_r);

endmodule : gpio_ctrl

/* verilog/gpio_in_sync.sv */
`timescale 1ns/1ns

module gpio_in_sync #(
  parameter int WIDTH = 12
) (
  input  logic             clk,
  input  logic             nrst,
  input  logic [WIDTH-1:0] i_pins,
  output logic [WIDTH-1:0] o_level,
  output logic [WIDTH-1:0] o_rise
);

  logic [WIDTH-1:0] sync1;
  logic [WIDTH-1:0] sync2;
  logic [WIDTH-1:0] prev;

  // two flops against metastability
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= i_pins;
      sync2 <= sync1;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      prev <= '0;  // no edge out of reset
    end else begin
      prev <= sync2;
    end
  end

  assign o_level = sync2;
  assign o_rise  = sync2 & ~prev;  // low to high since last cycle

endmodule : gpio_in_sync

/* verilog/gpio_pkg.sv */
package gpio_pkg;

  // word indices of the register map
  localparam bus_pkg::bus_addr_t REG_DIR      = 4'd0;
  localparam bus_pkg::bus_addr_t REG_IN       = 4'd1;  // read-only
  localparam bus_pkg::bus_addr_t REG_OUT      = 4'd2;
  localparam bus_pkg::bus_addr_t REG_IRQ_EN   = 4'd3;
  localparam bus_pkg::bus_addr_t REG_IRQ_STAT = 4'd4;  // write 1 to clear

  // all pins start as inputs
  localparam bus_pkg::bus_data_t DIR_RESET = 32'hffff_ffff;

endpackage : gpio_pkg

/* verilog/gpio_top.sv */
`timescale 1ns/1ns

module gpio_top #(
  parameter int WIDTH = 12,
  parameter int DEPTH = 4
) (
  input  logic               clk,
  input  logic               nrst,
  input  logic               i_req_valid,
  input  logic               i_req_we,
  input  bus_pkg::bus_addr_t i_req_addr,
  input  bus_pkg::bus_data_t i_req_wdata,
  input  bus_pkg::bus_strb_t i_req_strb,
  output logic               o_credit,
  output logic               o_rsp_valid,
  output bus_pkg::bus_data_t o_rsp_rdata,
  input  logic [WIDTH-1:0]   i_gpio,
  output logic [WIDTH-1:0]   o_gpio,
  output logic [WIDTH-1:0]   o_gpio_dir,
  output logic               o_irq
);

  logic [WIDTH-1:0] pin_level;
  logic [WIDTH-1:0] pin_rise;

  bus_req_if req_if ();

  req_queue #(
    .DEPTH (DEPTH)
  ) req_queue_i (
    .clk      (clk),
    .nrst     (nrst),
    .i_valid  (i_req_valid),
    .i_we     (i_req_we),
    .i_addr   (i_req_addr),
    .i_wdata  (i_req_wdata),
    .i_strb   (i_req_strb),
    .o_credit (o_credit),
    .q        (req_if.src)
  );

  gpio_in_sync #(
    .WIDTH (WIDTH)
  ) gpio_in_sync_i (
    .clk     (clk),
    .nrst    (nrst),
    .i_pins  (i_gpio),
    .o_level (pin_level),
    .o_rise  (pin_rise)
  );

  gpio_ctrl #(
    .WIDTH (WIDTH)
  ) gpio_ctrl_i (
    .clk         (clk),
    .nrst        (nrst),
    .q           (req_if.dst),
    .i_level     (pin_level),
    .i_rise      (pin_rise),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_rdata (o_rsp_rdata),
    .o_gpio      (o_gpio),
    .o_gpio_dir  (o_gpio_dir),
    .o_irq       (o_irq)
  );

endmodule : gpio_top

/* verilog/req_queue.sv */
`timescale 1ns/1ns

module req_queue #(
  parameter int DEPTH = 4
) (
  input  logic               clk,
  input  logic               nrst,
  input  logic               i_valid,
  input  logic               i_we,
  input  bus_pkg::bus_addr_t i_addr,
  input  bus_pkg::bus_data_t i_wdata,
  input  bus_pkg::bus_strb_t i_strb,
  output logic               o_credit,
  bus_req_if.src             q
);
  import bus_pkg::*;

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic      mem_we    [DEPTH];
  bus_addr_t mem_addr  [DEPTH];
  bus_data_t mem_wdata [DEPTH];
  bus_strb_t mem_strb  [DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;
  logic          full;
  logic          empty;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);
  assign push  = i_valid && !full;  // no credit left, request dropped
  assign pop   = !empty;            // controller never stalls

  always_ff @(posedge clk) begin
    if (push) begin
      mem_we[wr_ptr]    <= i_we;
      mem_addr[wr_ptr]  <= i_addr;
      mem_wdata[wr_ptr] <= i_wdata;
      mem_strb[wr_ptr]  <= i_strb;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(push) - CW'(pop);
    end
  end

  assign q.valid = pop;
  assign q.we    = mem_we[rd_ptr];
  assign q.addr  = mem_addr[rd_ptr];
  assign q.wdata = mem_wdata[rd_ptr];
  assign q.strb  = mem_strb[rd_ptr];

  assign o_credit = pop;  // one credit back per retired entry

endmodule : req_queue
